/* sim.f */
verilog/mem_map_pkg.sv
verilog/bus_pkg.sv
verilog/int_bus_port.sv
verilog/tcm_dp.sv
verilog/rpm_mem.sv
verilog/incore_mem_top.sv
bench/ext_mem_model.sv
bench/tb_incore_mem.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the in-core memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module tb_incore_mem --Mdir obj_dir \
  > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/Vtb_incore_mem > sim.log 2>&1

grep -q "Verification passed" sim.log && echo "Simulation PASSED" \
  || { echo "Simulation FAILED, see sim.log"; exit 1; }

/* bench/tb_incore_mem.sv */
// Testbench of the in-core memory block that plays the core on the fetch, LSU and probe ports
`timescale 1ns/100ps

module tb_incore_mem;

  import mem_map_pkg::*;
  import bus_pkg::*;

  localparam logic [31:0] ERR_START = 32'h8000_0100;  // Error window of both models
  localparam logic [31:0] ERR_SIZE  = 32'h0000_0040;
  localparam logic [31:0] EXT_BASE  = 32'h8000_0000;  // LSU words outside the window
  localparam logic [31:0] FETCH_EXT = 32'h2000_0000;  // Never written so reads return the fill
  localparam int          TIMEOUT   = 200;            // Cycles per wait

  typedef struct packed {
    logic     chk_data;  // Low for writes since their rdata is don't care
    obi_rsp_t rsp;
  } exp_t;

  logic                   clk_i    = 1'b1;
  logic                   arst_n_i = 1'b1;
  logic                   instr_req_i;
  obi_req_t               instr_pld_i;
  logic                   instr_gnt_o;
  logic                   instr_rvalid_o;
  obi_rsp_t               instr_rsp_o;
  logic                   data_req_i;
  obi_req_t               data_pld_i;
  logic                   data_gnt_o;
  logic                   data_rvalid_o;
  obi_rsp_t               data_rsp_o;
  logic                   ext_instr_req_o;
  obi_req_t               ext_instr_pld_o;
  logic                   ext_instr_gnt_i;
  logic                   ext_instr_rvalid_i;
  obi_rsp_t               ext_instr_rsp_i;
  logic                   ext_data_req_o;
  obi_req_t               ext_data_pld_o;
  logic                   ext_data_gnt_i;
  logic                   ext_data_rvalid_i;
  obi_rsp_t               ext_data_rsp_i;
  logic                   rpm_probe_req_i;
  logic [RPM_IDX_W-1:0]   rpm_probe_idx_i;
  logic                   rpm_probe_rvalid_o;
  rpm_probe_rsp_t         rpm_probe_rsp_o;

  logic [31:0]    shadow [logic [31:0]];  // Expected memory image
  exp_t           instr_exp_q [$];
  exp_t           data_exp_q [$];
  rpm_probe_rsp_t probe_exp_q [$];
  int unsigned    cyc          = 0;
  int unsigned    data_rsp_cyc = 0;  // Cycle of last LSU response
  int unsigned    rule_stalls  = 0;  // LSU cycles held off by the acceptance rule

  always #50 clk_i = ~clk_i;  // 100 ns period

  incore_mem_top u_incore_mem_top (.*);

  ext_mem_model #(
    .ERR_START (ERR_START),
    .ERR_SIZE  (ERR_SIZE)
  ) u_ext_instr (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (ext_instr_req_o),
    .pld_i    (ext_instr_pld_o),
    .gnt_o    (ext_instr_gnt_i),
    .rvalid_o (ext_instr_rvalid_i),
    .rsp_o    (ext_instr_rsp_i)
  );

  ext_mem_model #(
    .ERR_START (ERR_START),
    .ERR_SIZE  (ERR_SIZE)
  ) u_ext_data (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (ext_data_req_o),
    .pld_i    (ext_data_pld_o),
    .gnt_o    (ext_data_gnt_i),
    .rvalid_o (ext_data_rvalid_i),
    .rsp_o    (ext_data_rsp_i)
  );

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic logic in_err_window(input logic [31:0] addr);
    return (addr >= ERR_START) && (addr < ERR_START + ERR_SIZE);
  endfunction

  // Byte lanes with be set take the new data
  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wdata,
                                              input logic [3:0] be);
    logic [31:0] res;
    int          b;
    res = old;
    for (b = 0; b < 4; b++) begin
      if (be[b]) res[8*b +: 8] = wdata[8*b +: 8];
    end
    return res;
  endfunction

  function automatic obi_rsp_t ref_read(input logic [31:0] addr);
    obi_rsp_t rsp;
    rsp.err = in_err_window(addr);
    if (rsp.err) rsp.rdata = 32'h0;
    else if (shadow.exists(addr)) rsp.rdata = shadow[addr];
    else rsp.rdata = addr ^ 32'h5A5A_A5A5;  // External fill pattern
    return rsp;
  endfunction

  function automatic obi_req_t mk_req(input logic [31:0] addr, input logic we,
                                      input logic [3:0] be, input logic [31:0] wdata);
    obi_req_t req;
    req.addr  = addr;
    req.we    = we;
    req.be    = be;
    req.wdata = wdata;
    return req;
  endfunction

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_rsp(input string name, input obi_rsp_t got, input obi_rsp_t exp,
                           input logic chk_data);
    if ((chk_data && got !== exp) || got.err !== exp.err)
      abort_run($sformatf("ERR %s exp %h got %h", name, exp, got));
  endtask

  task automatic check_probe(input rpm_probe_rsp_t got, input rpm_probe_rsp_t exp);
    if (got !== exp) abort_run($sformatf("ERR rpm_probe_rsp_o exp %h got %h", exp, got));
  endtask

  // Pops an expected entry on every rvalid
  always @(posedge clk_i) begin : compare
    exp_t exp;
    cyc <= cyc + 1;
    if (!arst_n_i && (instr_rvalid_o !== 1'b0 || data_rvalid_o !== 1'b0 ||
        rpm_probe_rvalid_o !== 1'b0 || ext_instr_req_o !== 1'b0 || ext_data_req_o !== 1'b0))
      abort_run("A valid or an external request was high during reset");
    if (arst_n_i && $isunknown({instr_rvalid_o, data_rvalid_o, rpm_probe_rvalid_o}))
      abort_run("A response valid is unknown after reset");
    if (arst_n_i && data_req_i && !data_gnt_o && !ext_data_req_o) rule_stalls++;
    if (data_rvalid_o === 1'b1) begin
      if (data_exp_q.size() == 0) abort_run("LSU port answered with nothing owed");
      else begin
        exp          = data_exp_q.pop_front();
        data_rsp_cyc = cyc;
        check_rsp("data_rsp_o", data_rsp_o, exp.rsp, exp.chk_data);
      end
    end
    if (instr_rvalid_o === 1'b1) begin
      if (instr_exp_q.size() == 0) abort_run("Fetch port answered with nothing owed");
      else begin
        exp = instr_exp_q.pop_front();
        check_rsp("instr_rsp_o", instr_rsp_o, exp.rsp, exp.chk_data);
      end
    end
    if (rpm_probe_rvalid_o === 1'b1) begin
      if (probe_exp_q.size() == 0) abort_run("Probe port answered with no probe issued");
      else check_probe(rpm_probe_rsp_o, probe_exp_q.pop_front());
    end
  end

  ////////////////////////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////////////////////////

  // Holds the request until granted and logs the expected response
  task automatic send_req(input logic is_instr, input obi_req_t pld, output int unsigned gnt_cyc);
    exp_t exp;
    logic granted;
    int   n;
    @(negedge clk_i);
    instr_req_i = is_instr;
    data_req_i  = !is_instr;  // One host port at a time
    if (is_instr) instr_pld_i = pld;
    else data_pld_i = pld;
    granted = 1'b0;
    for (n = 0; n < TIMEOUT && !granted; n++) begin
      @(posedge clk_i);
      granted = is_instr ? instr_gnt_o : data_gnt_o;
    end
    if (!granted) abort_run("Timeout waiting for gnt on a host port");
    gnt_cyc      = cyc;
    exp.chk_data = !pld.we;
    exp.rsp      = ref_read(pld.addr);
    if (pld.we && !in_err_window(pld.addr))
      shadow[pld.addr] = merge_bytes(exp.rsp.rdata, pld.wdata, pld.be);
    if (is_instr) instr_exp_q.push_back(exp);
    else data_exp_q.push_back(exp);
  endtask

  task automatic idle_ports();
    @(negedge clk_i);
    instr_req_i = 1'b0;
    data_req_i  = 1'b0;
  endtask

  // One cycle probe pulse on the pair at the even word
  task automatic probe_rpm(input logic [RPM_IDX_W-1:0] idx);
    rpm_probe_rsp_t exp;
    obi_rsp_t       word;
    logic [31:0]    base;
    base   = RPM_START + ((32'(idx) & ~32'd1) << 2);
    word   = ref_read(base);
    exp.b0 = word.rdata;
    word   = ref_read(base + 32'd4);
    exp.b1 = word.rdata;
    @(negedge clk_i);
    rpm_probe_req_i = 1'b1;
    rpm_probe_idx_i = idx;
    probe_exp_q.push_back(exp);
    @(negedge clk_i);
    rpm_probe_req_i = 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while ((instr_exp_q.size() + data_exp_q.size() + probe_exp_q.size()) != 0 && n < TIMEOUT) begin
      @(posedge clk_i);
      n++;
    end
    if ((instr_exp_q.size() + data_exp_q.size() + probe_exp_q.size()) != 0)
      abort_run("Timeout waiting for owed responses");
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin : stimulus
    int unsigned g;
    int unsigned i;
    int unsigned t;
    int unsigned stalls_before_mix;
    logic [31:0] pool [4];
    void'($urandom(99));
    instr_req_i     = 1'b0;
    instr_pld_i     = '0;
    data_req_i      = 1'b0;
    data_pld_i      = '0;
    rpm_probe_req_i = 1'b0;
    rpm_probe_idx_i = '0;
    @(negedge clk_i);
    arst_n_i = 1'b0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;

    // Write then read back to back with one cycle read latency
    send_req(1'b0, mk_req(TCM_DATA_START, 1'b1, 4'hF, 32'hC0DE_0001), g);
    send_req(1'b0, mk_req(TCM_DATA_START, 1'b0, 4'h0, 32'h0), g);
    idle_ports();
    wait_drain();
    if (data_rsp_cyc != g + 1)
      abort_run($sformatf("ERR data_rvalid_o latency exp %h got %h", 1, data_rsp_cyc - g));

    // Data TCM with byte enables
    for (i = 0; i < 8; i++) send_req(1'b0, mk_req(TCM_DATA_START + 4*i, 1'b1, 4'hF, $urandom), g);
    for (i = 0; i < 24; i++)
      send_req(1'b0, mk_req(TCM_DATA_START + 4*$urandom_range(7), 1'b1, 4'($urandom), $urandom), g);
    for (i = 0; i < 8; i++) send_req(1'b0, mk_req(TCM_DATA_START + 4*i, 1'b0, 4'h0, 32'h0), g);
    idle_ports();
    wait_drain();

    // Instruction TCM loaded by the LSU, read by fetch
    for (i = 0; i < 8; i++) send_req(1'b0, mk_req(TCM_INST_START + 4*i, 1'b1, 4'hF, $urandom), g);
    for (i = 0; i < 8; i++) send_req(1'b1, mk_req(TCM_INST_START + 4*i, 1'b0, 4'h0, 32'h0), g);
    idle_ports();
    wait_drain();

    // Protection words seen through the probe
    for (i = 16; i < 24; i++) send_req(1'b0, mk_req(RPM_START + 4*i, 1'b1, 4'hF, $urandom), g);
    idle_ports();
    wait_drain();
    for (i = 16; i < 24; i++) probe_rpm(RPM_IDX_W'(i));
    wait_drain();

    // External words with some inside the error window
    for (i = 0; i < 16; i++) send_req(1'b0, mk_req(EXT_BASE + 32*i, 1'b1, 4'hF, $urandom), g);
    for (i = 0; i < 8; i++)
      send_req(1'b0, mk_req(EXT_BASE + 32*$urandom_range(15), 1'b1, 4'($urandom), $urandom), g);
    for (i = 0; i < 16; i++) send_req(1'b0, mk_req(EXT_BASE + 32*i, 1'b0, 4'h0, 32'h0), g);
    for (i = 0; i < 4; i++) send_req(1'b1, mk_req(FETCH_EXT + 4*i, 1'b0, 4'h0, 32'h0), g);
    idle_ports();
    wait_drain();

    // Random back to back mix over all LSU targets
    stalls_before_mix = rule_stalls;
    pool[0] = TCM_INST_START + 32'h100;
    pool[1] = TCM_DATA_START + 32'h100;
    pool[2] = RPM_START + 32'h100;
    pool[3] = ERR_START - 32'h10;  // Straddles the error window
    for (t = 0; t < 4; t++) begin
      for (i = 0; i < 8; i++) send_req(1'b0, mk_req(pool[t] + 4*i, 1'b1, 4'hF, $urandom), g);
    end
    for (i = 0; i < 64; i++) begin
      t = $urandom_range(3);
      send_req(1'b0, mk_req(pool[t] + 4*$urandom_range(7), 1'($urandom_range(1)),
                            4'($urandom), $urandom), g);
    end
    idle_ports();
    wait_drain();

    if (rule_stalls == stalls_before_mix) begin
      abort_run("Acceptance rule never held gnt low during the mixed run");
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule

/* bench/ext_mem_model.sv */
// External memory responder with random grant stalls, random latency and an error window
`timescale 1ns/100ps

module ext_mem_model #(
  parameter logic [31:0] ERR_START = 32'h8000_0100,  // First byte answered with err
  parameter logic [31:0] ERR_SIZE  = 32'h0000_0040,
  parameter int          MAX_LAT   = 4               // Extra cycles before rvalid
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              req_i,
  input  bus_pkg::obi_req_t pld_i,
  output logic              gnt_o,
  output logic              rvalid_o,
  output bus_pkg::obi_rsp_t rsp_o
);

  import bus_pkg::*;

  logic [31:0] mem [logic [31:0]];  // Sparse storage
  obi_rsp_t    rsp_q [$];           // Responses in request order
  int unsigned due_q [$];           // Cycle each response may leave
  int unsigned cyc      = 0;
  logic        gnt_q    = 1'b0;
  logic        rvalid_q = 1'b0;
  obi_rsp_t    rsp_q0   = '0;

  assign gnt_o    = gnt_q;
  assign rvalid_o = rvalid_q;
  assign rsp_o    = rsp_q0;

  ////////////////////////////////////////////////////////////
  // Accept on the rising edge
  ////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin : accept
    obi_rsp_t    rsp;
    logic [31:0] word;
    int          b;
    if (arst_n_i && req_i && gnt_q) begin
      // Unwritten words read back as the address scrambled
      word      = mem.exists(pld_i.addr) ? mem[pld_i.addr] : (pld_i.addr ^ 32'h5A5A_A5A5);
      rsp.err   = (pld_i.addr >= ERR_START) && (pld_i.addr < ERR_START + ERR_SIZE);
      rsp.rdata = rsp.err ? 32'h0 : word;  // Old word, also on writes
      if (pld_i.we && !rsp.err) begin
        for (b = 0; b < 4; b++) begin
          if (pld_i.be[b]) word[8*b +: 8] = pld_i.wdata[8*b +: 8];
        end
        mem[pld_i.addr] = word;
      end
      rsp_q.push_back(rsp);
      due_q.push_back(cyc + 1 + $urandom_range(MAX_LAT));
    end
    cyc++;
  end

  // Grant and response change on the falling edge only
  always @(negedge clk_i) begin
    if (!arst_n_i) begin
      gnt_q    = 1'b0;
      rvalid_q = 1'b0;
      rsp_q.delete();
      due_q.delete();
    end else begin
      gnt_q = ($urandom_range(3) != 0);  // Stall roughly one cycle in four
      if (rsp_q.size() != 0 && due_q[0] <= cyc) begin
        rvalid_q = 1'b1;
        rsp_q0   = rsp_q.pop_front();
        void'(due_q.pop_front());
      end else begin
        rvalid_q = 1'b0;
      end
    end
  end

endmodule

/* verilog/incore_mem_top.sv */
// In-core private address space: internal bus, instruction and data TCMs, protection memory
`timescale 1ns/100ps

module incore_mem_top (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  // Fetch host
  input  logic                              instr_req_i,
  input  bus_pkg::obi_req_t                 instr_pld_i,
  output logic                              instr_gnt_o,
  output logic                              instr_rvalid_o,
  output bus_pkg::obi_rsp_t                 instr_rsp_o,
  // LSU host
  input  logic                              data_req_i,
  input  bus_pkg::obi_req_t                 data_pld_i,
  output logic                              data_gnt_o,
  output logic                              data_rvalid_o,
  output bus_pkg::obi_rsp_t                 data_rsp_o,
  // External instruction port
  output logic                              ext_instr_req_o,
  output bus_pkg::obi_req_t                 ext_instr_pld_o,
  input  logic                              ext_instr_gnt_i,
  input  logic                              ext_instr_rvalid_i,
  input  bus_pkg::obi_rsp_t                 ext_instr_rsp_i,
  // External data port
  output logic                              ext_data_req_o,
  output bus_pkg::obi_req_t                 ext_data_pld_o,
  input  logic                              ext_data_gnt_i,
  input  logic                              ext_data_rvalid_i,
  input  bus_pkg::obi_rsp_t                 ext_data_rsp_i,
  // Implicit probe of the protection memory
  input  logic                              rpm_probe_req_i,
  input  logic [mem_map_pkg::RPM_IDX_W-1:0] rpm_probe_idx_i,
  output logic                              rpm_probe_rvalid_o,
  output bus_pkg::rpm_probe_rsp_t           rpm_probe_rsp_o
);

  import mem_map_pkg::*;
  import bus_pkg::*;

  // Fetch side reaches the instruction TCM only
  logic [1:1]             instr_mem_req;
  mem_req_t               instr_mem_pld;
  logic [1:1]             instr_mem_rvalid;
  logic [1:1][DATA_W-1:0] instr_mem_rdata;

  // LSU side, indexed by tgt_e
  logic [3:1]             data_mem_req;
  mem_req_t               data_mem_pld;
  logic [3:1]             data_mem_rvalid;
  logic [3:1][DATA_W-1:0] data_mem_rdata;

  ////////////////////////////////////////////////////////////
  // Internal bus ports
  ////////////////////////////////////////////////////////////

  int_bus_port #(
    .NR_TGT (2)
  ) u_instr_port (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .host_req_i     (instr_req_i),
    .host_req_pld_i (instr_pld_i),
    .host_gnt_o     (instr_gnt_o),
    .host_rvalid_o  (instr_rvalid_o),
    .host_rsp_o     (instr_rsp_o),
    .mem_req_o      (instr_mem_req),
    .mem_pld_o      (instr_mem_pld),
    .mem_rvalid_i   (instr_mem_rvalid),
    .mem_rdata_i    (instr_mem_rdata),
    .ext_req_o      (ext_instr_req_o),
    .ext_pld_o      (ext_instr_pld_o),
    .ext_gnt_i      (ext_instr_gnt_i),
    .ext_rvalid_i   (ext_instr_rvalid_i),
    .ext_rsp_i      (ext_instr_rsp_i)
  );

  int_bus_port #(
    .NR_TGT (4)
  ) u_data_port (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .host_req_i     (data_req_i),
    .host_req_pld_i (data_pld_i),
    .host_gnt_o     (data_gnt_o),
    .host_rvalid_o  (data_rvalid_o),
    .host_rsp_o     (data_rsp_o),
    .mem_req_o      (data_mem_req),
    .mem_pld_o      (data_mem_pld),
    .mem_rvalid_i   (data_mem_rvalid),
    .mem_rdata_i    (data_mem_rdata),
    .ext_req_o      (ext_data_req_o),
    .ext_pld_o      (ext_data_pld_o),
    .ext_gnt_i      (ext_data_gnt_i),
    .ext_rvalid_i   (ext_data_rvalid_i),
    .ext_rsp_i      (ext_data_rsp_i)
  );

  ////////////////////////////////////////////////////////////
  // Memories
  ////////////////////////////////////////////////////////////

  // Port a from LSU, port b serves fetch
  tcm_dp #(
    .WORDS (TCM_INST_WORDS)
  ) u_tcm_inst (
    .clk_i      (clk_i),
    .a_req_i    (data_mem_req[TGT_TCM_INST]),
    .a_pld_i    (data_mem_pld),
    .a_rvalid_o (data_mem_rvalid[TGT_TCM_INST]),
    .a_rdata_o  (data_mem_rdata[TGT_TCM_INST]),
    .b_req_i    (instr_mem_req[TGT_TCM_INST]),
    .b_idx_i    (instr_mem_pld.idx),
    .b_rvalid_o (instr_mem_rvalid[TGT_TCM_INST]),
    .b_rdata_o  (instr_mem_rdata[TGT_TCM_INST])
  );

  tcm_dp #(
    .WORDS (TCM_DATA_WORDS)
  ) u_tcm_data (
    .clk_i      (clk_i),
    .a_req_i    (data_mem_req[TGT_TCM_DATA]),
    .a_pld_i    (data_mem_pld),
    .a_rvalid_o (data_mem_rvalid[TGT_TCM_DATA]),
    .a_rdata_o  (data_mem_rdata[TGT_TCM_DATA]),
    .b_req_i    (1'b0),  // No fetch from data TCM
    .b_idx_i    ('0),
    .b_rvalid_o (),
    .b_rdata_o  ()
  );

  rpm_mem u_rpm (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .m_req_i        (data_mem_req[TGT_RPM]),
    .m_pld_i        (data_mem_pld),
    .m_rvalid_o     (data_mem_rvalid[TGT_RPM]),
    .m_rdata_o      (data_mem_rdata[TGT_RPM]),
    .probe_req_i    (rpm_probe_req_i),
    .probe_idx_i    (rpm_probe_idx_i),
    .probe_rvalid_o (rpm_probe_rvalid_o),
    .probe_rsp_o    (rpm_probe_rsp_o)
  );

endmodule

/* verilog/rpm_mem.sv */
// Region protection memory, machine read/write port plus aligned pair probe port
`timescale 1ns/100ps

module rpm_mem (
  input  logic                               clk_i,
  input  logic                               arst_n_i,
  // Machine port, reached through the LSU
  input  logic                               m_req_i,
  input  bus_pkg::mem_req_t                  m_pld_i,
  output logic                               m_rvalid_o,
  output logic [bus_pkg::DATA_W-1:0]         m_rdata_o,
  // Implicit probe of the trie walker
  input  logic                               probe_req_i,
  input  logic [mem_map_pkg::RPM_IDX_W-1:0]  probe_idx_i,
  output logic                               probe_rvalid_o,
  output bus_pkg::rpm_probe_rsp_t            probe_rsp_o
);

  import mem_map_pkg::*;
  import bus_pkg::*;

  // Even and odd words in separate banks so a pair reads in one cycle
  logic [DATA_W-1:0]    mem_even [RPM_WORDS/2];
  logic [DATA_W-1:0]    mem_odd  [RPM_WORDS/2];
  logic [RPM_IDX_W-2:0] m_row;      // Row within a bank
  logic                 m_bank;     // 1 selects odd bank
  logic [RPM_IDX_W-2:0] probe_row;  // Low bit dropped, pair is aligned

  assign m_row     = m_pld_i.idx[RPM_IDX_W-1:1];
  assign m_bank    = m_pld_i.idx[0];
  assign probe_row = probe_idx_i[RPM_IDX_W-1:1];

  ////////////////////////////////////////////////////////////
  // Machine port
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (m_req_i) begin
      m_rdata_o <= m_bank ? mem_odd[m_row] : mem_even[m_row];
      if (m_pld_i.we) begin
        for (int b = 0; b < BE_W; b++) begin
          if (m_pld_i.be[b] && m_bank) mem_odd[m_row][8*b +: 8] <= m_pld_i.wdata[8*b +: 8];
          if (m_pld_i.be[b] && !m_bank) mem_even[m_row][8*b +: 8] <= m_pld_i.wdata[8*b +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Probe port
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (probe_req_i) begin
      probe_rsp_o.b0 <= mem_even[probe_row];  // Word at even index
      probe_rsp_o.b1 <= mem_odd[probe_row];   // Its neighbour
    end
  end

  // Valids for both ports
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      m_rvalid_o     <= 1'b0;
      probe_rvalid_o <= 1'b0;
    end else begin
      m_rvalid_o     <= m_req_i;
      probe_rvalid_o <= probe_req_i;
    end
  end

endmodule

/* verilog/tcm_dp.sv */
// Tightly coupled word memory, byte-enabled read/write port a and read-only port b
`timescale 1ns/100ps

module tcm_dp #(
  parameter int WORDS = mem_map_pkg::TCM_INST_WORDS  // Depth in words
) (
  input  logic                            clk_i,
  // Port a, LSU side
  input  logic                            a_req_i,
  input  bus_pkg::mem_req_t               a_pld_i,
  output logic                            a_rvalid_o,
  output logic [bus_pkg::DATA_W-1:0]      a_rdata_o,
  // Port b, fetch side
  input  logic                            b_req_i,
  input  logic [bus_pkg::MEM_IDX_W-1:0]   b_idx_i,
  output logic                            b_rvalid_o,
  output logic [bus_pkg::DATA_W-1:0]      b_rdata_o
);

  import bus_pkg::*;

  logic [DATA_W-1:0] mem [WORDS];  // Word array

  ////////////////////////////////////////////////////////////
  // Port a
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (a_req_i) begin
      a_rdata_o <= mem[a_pld_i.idx];  // Old word, also on writes
      if (a_pld_i.we) begin
        for (int b = 0; b < BE_W; b++) begin
          if (a_pld_i.be[b]) begin
            mem[a_pld_i.idx][8*b +: 8] <= a_pld_i.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  // Every request answers next cycle
  always_ff @(posedge clk_i) begin
    a_rvalid_o <= a_req_i;
  end

  ////////////////////////////////////////////////////////////
  // Port b
  ////////////////////////////////////////////////////////////

  // Same-cycle write on port a is not seen here, old word returned
  always_ff @(posedge clk_i) begin
    if (b_req_i) begin
      b_rdata_o <= mem[b_idx_i];
    end
  end

  always_ff @(posedge clk_i) begin
    b_rvalid_o <= b_req_i;  // Single cycle read latency
  end

endmodule

/* verilog/int_bus_port.sv */
// Host port of the internal bus, decodes requests onto memories or external port
`timescale 1ns/100ps

module int_bus_port #(
  parameter int NR_TGT = 4  // 2 for fetch, 4 for LSU
) (
  input  logic                                   clk_i,
  input  logic                                   arst_n_i,
  // Host side
  input  logic                                   host_req_i,
  input  bus_pkg::obi_req_t                      host_req_pld_i,
  output logic                                   host_gnt_o,
  output logic                                   host_rvalid_o,
  output bus_pkg::obi_rsp_t                      host_rsp_o,
  // Internal memories, bit n serves target n
  output logic [NR_TGT-1:1]                      mem_req_o,
  output bus_pkg::mem_req_t                      mem_pld_o,
  input  logic [NR_TGT-1:1]                      mem_rvalid_i,
  input  logic [NR_TGT-1:1][bus_pkg::DATA_W-1:0] mem_rdata_i,
  // Pass-through to the outside world
  output logic                                   ext_req_o,
  output bus_pkg::obi_req_t                      ext_pld_o,
  input  logic                                   ext_gnt_i,
  input  logic                                   ext_rvalid_i,
  input  bus_pkg::obi_rsp_t                      ext_rsp_i
);

  import mem_map_pkg::*;
  import bus_pkg::*;

  tgt_e                                   req_tgt;   // Target of the pending request
  logic [ADDR_W-1:0]                      req_base;  // Region base of that target
  logic [ADDR_W-1:0]                      req_off;
  tgt_e                                   owed_tgt;  // Target still owing responses
  logic [$clog2(MAX_OUTSTANDING+1)-1:0]   out_cnt;
  logic                                   can_acc;
  logic                                   acc;
  logic                                   rsp_valid;
  obi_rsp_t                               rsp;

  // Aligned power-of-two region check
  function automatic logic in_region(input logic [ADDR_W-1:0] addr,
                                     input logic [ADDR_W-1:0] base,
                                     input logic [ADDR_W-1:0] size);
    return (addr & ~(size - 1'b1)) == base;
  endfunction

  ////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    req_tgt  = TGT_EXT;  // Anything unmatched leaves the core
    req_base = '0;
    if (in_region(host_req_pld_i.addr, TCM_INST_START, TCM_INST_SIZE)) begin
      req_tgt  = TGT_TCM_INST;
      req_base = TCM_INST_START;
    end else if (NR_TGT > 2 && in_region(host_req_pld_i.addr, TCM_DATA_START, TCM_DATA_SIZE)) begin
      req_tgt  = TGT_TCM_DATA;
      req_base = TCM_DATA_START;
    end else if (NR_TGT > 2 && in_region(host_req_pld_i.addr, RPM_START, RPM_SIZE)) begin
      req_tgt  = TGT_RPM;
      req_base = RPM_START;
    end
  end

  assign req_off = host_req_pld_i.addr - req_base;  // Byte offset in region

  // Accept only below the limit and only towards the target already owed
  assign can_acc = (out_cnt < MAX_OUTSTANDING) && ((out_cnt == '0) || (req_tgt == owed_tgt));

  // Once can_acc rises it holds until grant, so ext req is never retracted
  assign ext_req_o  = host_req_i & can_acc & (req_tgt == TGT_EXT);
  assign ext_pld_o  = host_req_pld_i;
  assign host_gnt_o = host_req_i & can_acc & ((req_tgt == TGT_EXT) ? ext_gnt_i : 1'b1);
  assign acc        = host_req_i & host_gnt_o;

  // One-hot memory request
  always_comb begin
    for (int t = 1; t < NR_TGT; t++) begin
      mem_req_o[t] = acc && (req_tgt == tgt_e'(t));
    end
  end

  assign mem_pld_o.idx   = req_off[MEM_IDX_W+1:2];  // Byte offset to word index
  assign mem_pld_o.we    = host_req_pld_i.we;
  assign mem_pld_o.be    = host_req_pld_i.be;
  assign mem_pld_o.wdata = host_req_pld_i.wdata;

  ////////////////////////////////////////////////////////////
  // Outstanding tracking and response mux
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_cnt  <= '0;
      owed_tgt <= TGT_EXT;
    end else begin
      if (acc) owed_tgt <= req_tgt;
      case ({acc, host_rvalid_o})
        2'b10:   out_cnt <= out_cnt + 1'b1;  // New request only
        2'b01:   out_cnt <= out_cnt - 1'b1;  // Response only
        default: out_cnt <= out_cnt;         // Neither or both
      endcase
    end
  end

  // Only the owed target may answer
  always_comb begin
    rsp_valid = 1'b0;
    rsp       = '0;
    if (owed_tgt == TGT_EXT) begin
      rsp_valid = ext_rvalid_i;
      rsp       = ext_rsp_i;
    end else begin
      for (int t = 1; t < NR_TGT; t++) begin
        if (owed_tgt == tgt_e'(t)) begin
          rsp_valid = mem_rvalid_i[t];
          rsp.rdata = mem_rdata_i[t];
          rsp.err   = 1'b0;  // Memories never fault
        end
      end
    end
  end

  assign host_rvalid_o = rsp_valid & (out_cnt != '0);  // Ignore strays with nothing owed
  assign host_rsp_o    = rsp;

endmodule

/* verilog/bus_pkg.sv */
// Request and response payloads of the host, memory and probe ports
package bus_pkg;

  import mem_map_pkg::*;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int BE_W   = DATA_W / 8;  // One enable per byte lane

  // Largest memory decides the word index width
  localparam int MEM_MAX_WORDS =
    (TCM_INST_WORDS > TCM_DATA_WORDS) ?
      ((TCM_INST_WORDS > RPM_WORDS) ? TCM_INST_WORDS : RPM_WORDS) :
      ((TCM_DATA_WORDS > RPM_WORDS) ? TCM_DATA_WORDS : RPM_WORDS);
  localparam int MEM_IDX_W = $clog2(MEM_MAX_WORDS);

  // Host side request, 69 bits
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              we;
    logic [BE_W-1:0]   be;
    logic [DATA_W-1:0] wdata;
  } obi_req_t;

  // Host side response, 33 bits
  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;
  } obi_rsp_t;

  // Aligned pair read by the implicit probe
  typedef struct packed {
    logic [DATA_W-1:0] b0;  // Even word
    logic [DATA_W-1:0] b1;  // Odd word
  } rpm_probe_rsp_t;

  // Memory side request, address already turned into a word index
  typedef struct packed {
    logic [MEM_IDX_W-1:0] idx;
    logic                 we;
    logic [BE_W-1:0]      be;
    logic [DATA_W-1:0]    wdata;
  } mem_req_t;

endpackage

/* verilog/mem_map_pkg.sv */
// Address map of the private in-core window and route targets of the internal bus
package mem_map_pkg;

  ////////////////////////////////////////////////////////////
  // Internal window layout
  ////////////////////////////////////////////////////////////

  localparam logic [31:0] INT_BUS_START  = 32'h7000_0000;  // Base of the in-core window

  // Instruction TCM sits at the bottom of the window
  localparam logic [31:0] TCM_INST_START = INT_BUS_START;
  localparam logic [31:0] TCM_INST_SIZE  = 32'h0000_1000;  // 4 KiB

  localparam logic [31:0] TCM_DATA_START = INT_BUS_START + 32'h0000_2000;
  localparam logic [31:0] TCM_DATA_SIZE  = 32'h0000_1000;  // 4 KiB

  // Protection trie words right after the data TCM
  localparam logic [31:0] RPM_START      = TCM_DATA_START + TCM_DATA_SIZE;
  localparam logic [31:0] RPM_SIZE       = 32'h0000_0400;  // 1 KiB

  // Depths in 32-bit words
  localparam int TCM_INST_WORDS = TCM_INST_SIZE / 4;
  localparam int TCM_DATA_WORDS = TCM_DATA_SIZE / 4;
  localparam int RPM_WORDS      = RPM_SIZE / 4;
  localparam int RPM_IDX_W      = $clog2(RPM_WORDS);  // Probe index width

  // Route target, value doubles as memory port number on the bus
  typedef enum logic [1:0] {
    TGT_EXT      = 2'd0,  // Outside the window
    TGT_TCM_INST = 2'd1,
    TGT_TCM_DATA = 2'd2,
    TGT_RPM      = 2'd3
  } tgt_e;

  localparam int MAX_OUTSTANDING = 2;  // Responses one host port may owe

endpackage
